//--- src/cacheTypesPkg.sv
`default_nettype none

package cacheTypesPkg;

  // Byte address and line geometry
  localparam int addrWidth = 32;
  localparam int wordsPerLine = 4;
  // Word select plus byte select bits below the set index
  localparam int lineOffsetWidth = $clog2(wordsPerLine) + 2;

  // Controller sequencing
  typedef enum logic [3:0] {
    idle,
    lookup,
    writeBack,
    refill,
    complete,
    flushScan,
    flushWrite
  } ctrlState;

  // Per-way line status
  typedef struct packed {
    logic valid;
    logic dirty;
  } lineMeta;

endpackage

`default_nettype wire

//--- src/busTypesPkg.sv
`default_nettype none

package busTypesPkg;

  // Wishbone classic master outputs
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wbReq;

  // Wishbone classic slave outputs
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wbRsp;

  // Same pair serves the processor side and the memory side
  // sel is one bit per byte lane, lane 0 at dat[7:0]

endpackage

`default_nettype wire

//--- src/burstCounter.sv
`timescale 1ns/10ps
`default_nettype none

module burstCounter #(
  parameter int numSets = 16
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       clear,
  input  logic                       wordInc,
  input  logic                       flushInc,
  output logic [1:0]                 wordIdx,
  output logic                       lastWord,
  output logic [$clog2(numSets)-1:0] flushSet,
  output logic                       flushWay,
  output logic                       flushDone
);

  localparam int indexWidth = $clog2(numSets);

  logic [1:0]            wordCnt;
  // Top bit marks the end of the walk, bit 0 selects the way
  logic [indexWidth+1:0] walkCnt;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wordCnt <= '0;
      walkCnt <= '0;
    end else if (clear) begin
      wordCnt <= '0;
      walkCnt <= '0;
    end else begin
      // Wraps on its own after the last word of a line
      if (wordInc) begin
        wordCnt <= wordCnt + 2'd1;
      end
      if (flushInc) begin
        walkCnt <= walkCnt + 1'b1;
      end
    end
  end

  assign wordIdx = wordCnt;
  assign lastWord = (wordCnt == 2'(cacheTypesPkg::wordsPerLine - 1));
  assign flushWay = walkCnt[0];
  assign flushSet = walkCnt[indexWidth:1];
  assign flushDone = walkCnt[indexWidth+1];

endmodule

`default_nettype wire

//--- src/tagStore.sv
`timescale 1ns/10ps
`default_nettype none

module tagStore #(
  parameter int numSets = 16
) (
  input  logic                                              clk,
  input  logic                                              reset,
  input  logic [$clog2(numSets)-1:0]                        setIdx,
  input  logic                                              wayIdx,
  input  logic [cacheTypesPkg::addrWidth - $clog2(numSets)
                - cacheTypesPkg::lineOffsetWidth - 1:0]     lookupTag,
  input  logic                                              tagWrite,
  input  logic                                              metaWrite,
  input  logic                                              lruUpdate,
  input  cacheTypesPkg::lineMeta                            newMeta,
  output logic                                              hit,
  output logic                                              hitWay,
  output logic                                              victimWay,
  output cacheTypesPkg::lineMeta                            victimMeta,
  output logic [cacheTypesPkg::addrWidth - $clog2(numSets)
                - cacheTypesPkg::lineOffsetWidth - 1:0]     victimTag
);

  localparam int indexWidth = $clog2(numSets);
  localparam int tagWidth = cacheTypesPkg::addrWidth - indexWidth
                            - cacheTypesPkg::lineOffsetWidth;

  logic [tagWidth-1:0]    tags [numSets][2];
  cacheTypesPkg::lineMeta meta [numSets][2];
  // Per set, the way that was used least recently
  logic [numSets-1:0]     lru;
  logic [1:0]             wayHit;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lru <= '0;
      for (int s = 0; s < numSets; s++) begin
        meta[s][0] <= '0;
        meta[s][1] <= '0;
      end
    end else begin
      if (metaWrite) begin
        meta[setIdx][wayIdx] <= newMeta;
      end
      if (lruUpdate) begin
        lru[setIdx] <= ~wayIdx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tagWrite) begin
      tags[setIdx][wayIdx] <= lookupTag;
    end
  end

  // Both ways compared in parallel
  assign wayHit[0] = meta[setIdx][0].valid && (tags[setIdx][0] == lookupTag);
  assign wayHit[1] = meta[setIdx][1].valid && (tags[setIdx][1] == lookupTag);
  assign hit = |wayHit;
  assign hitWay = wayHit[1];

  // Empty way first, then LRU
  always_comb begin
    if (!meta[setIdx][0].valid) begin
      victimWay = 1'b0;
    end else if (!meta[setIdx][1].valid) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lru[setIdx];
    end
  end

  // Status of the line the controller points at: the miss victim,
  // or the walker's way while flushing
  assign victimMeta = meta[setIdx][wayIdx];
  assign victimTag = tags[setIdx][wayIdx];

endmodule

`default_nettype wire

//--- src/dataStore.sv
`timescale 1ns/10ps
`default_nettype none

module dataStore #(
  parameter int numSets = 16
) (
  input  logic                       clk,
  input  logic [$clog2(numSets)-1:0] setIdx,
  input  logic                       wayIdx,
  input  logic [1:0]                 wordIdx,
  input  logic                       dataWe,
  input  logic [3:0]                 dataSel,
  input  logic [31:0]                dataIn,
  output logic [31:0]                readWord
);

  // Set, way, word, then byte lanes
  logic [3:0][7:0] dataArray [numSets][2][cacheTypesPkg::wordsPerLine];

  always_ff @(posedge clk) begin
    if (dataWe) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (dataSel[lane]) begin
          dataArray[setIdx][wayIdx][wordIdx][lane] <= dataIn[8*lane +: 8];
        end
      end
    end
  end

  // Asynchronous read so write-back data follows wordIdx in the same cycle
  assign readWord = dataArray[setIdx][wayIdx][wordIdx];

endmodule

`default_nettype wire

//--- src/cacheController.sv
`timescale 1ns/10ps
`default_nettype none

module cacheController #(
  parameter int numSets = 16
) (
  input  logic                                              clk,
  input  logic                                              reset,
  input  busTypesPkg::wbReq                                 cpuReq,
  output busTypesPkg::wbRsp                                 cpuRsp,
  output busTypesPkg::wbReq                                 memReq,
  input  busTypesPkg::wbRsp                                 memRsp,
  input  logic                                              flushReq,
  output logic                                              flushBusy,
  input  logic                                              hit,
  input  logic                                              hitWay,
  input  logic                                              victimWay,
  input  cacheTypesPkg::lineMeta                            victimMeta,
  input  logic [cacheTypesPkg::addrWidth - $clog2(numSets)
                - cacheTypesPkg::lineOffsetWidth - 1:0]     victimTag,
  input  logic [31:0]                                       readWord,
  input  logic [1:0]                                        wordIdx,
  input  logic                                              lastWord,
  input  logic [$clog2(numSets)-1:0]                        flushSet,
  input  logic                                              flushWay,
  input  logic                                              flushDone,
  output logic                                              wordInc,
  output logic                                              flushInc,
  output logic                                              clear,
  output logic                                              tagWrite,
  output logic                                              metaWrite,
  output logic                                              lruUpdate,
  output logic [$clog2(numSets)-1:0]                        setIdx,
  output logic                                              wayIdx,
  output logic                                              dataWe,
  output logic [3:0]                                        dataSel,
  output logic [1:0]                                        dataWordIdx,
  output logic [31:0]                                       dataIn,
  output cacheTypesPkg::lineMeta                            newMeta
);

  localparam int indexWidth = $clog2(numSets);
  localparam int offsetWidth = cacheTypesPkg::lineOffsetWidth;
  localparam int tagWidth = cacheTypesPkg::addrWidth - indexWidth - offsetWidth;

  cacheTypesPkg::ctrlState state;
  cacheTypesPkg::ctrlState nextState;
  logic                    accWay;
  logic                    memGap;
  logic                    memXfer;
  logic                    memStb;
  logic                    memAck;
  logic                    lineDone;
  logic                    cpuValid;
  logic                    victimDirty;
  logic                    mergeWord;
  logic [1:0]              cpuWord;
  logic [indexWidth-1:0]   cpuSet;
  logic [tagWidth-1:0]     cpuTag;

  // Fields of the processor address
  assign cpuValid = cpuReq.cyc & cpuReq.stb;
  assign cpuWord = cpuReq.adr[offsetWidth-1 -: 2];
  assign cpuSet = cpuReq.adr[offsetWidth +: indexWidth];
  assign cpuTag = cpuReq.adr[cacheTypesPkg::addrWidth-1 -: tagWidth];
  assign victimDirty = victimMeta.valid & victimMeta.dirty;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= cacheTypesPkg::idle;
      memGap <= 1'b0;
    end else begin
      state <= nextState;
      // stb drops for one cycle after every memory ack
      memGap <= memAck;
    end
  end

  // Way chosen at lookup is kept for the whole miss
  always_ff @(posedge clk) begin
    if (state == cacheTypesPkg::lookup) begin
      accWay <= wayIdx;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cacheTypesPkg::idle: begin
        if (flushReq) begin
          nextState = cacheTypesPkg::flushScan;
        end else if (cpuValid) begin
          nextState = cacheTypesPkg::lookup;
        end
      end
      cacheTypesPkg::lookup: begin
        if (hit) begin
          nextState = cacheTypesPkg::complete;
        end else if (victimDirty) begin
          nextState = cacheTypesPkg::writeBack;
        end else begin
          nextState = cacheTypesPkg::refill;
        end
      end
      cacheTypesPkg::writeBack: begin
        if (lineDone) begin
          nextState = cacheTypesPkg::refill;
        end
      end
      cacheTypesPkg::refill: begin
        if (lineDone) begin
          nextState = cacheTypesPkg::complete;
        end
      end
      cacheTypesPkg::complete: nextState = cacheTypesPkg::idle;
      cacheTypesPkg::flushScan: begin
        // Walker wraps to set 0 when done, so test done first
        if (flushDone) begin
          nextState = cacheTypesPkg::idle;
        end else if (victimDirty) begin
          nextState = cacheTypesPkg::flushWrite;
        end
      end
      cacheTypesPkg::flushWrite: begin
        if (lineDone) begin
          nextState = cacheTypesPkg::flushScan;
        end
      end
      default: nextState = cacheTypesPkg::idle;
    endcase
  end

  // Memory bus, one word per handshake
  assign memXfer = state inside {cacheTypesPkg::writeBack, cacheTypesPkg::refill,
                                 cacheTypesPkg::flushWrite};
  assign memStb = memXfer & ~memGap;
  assign memAck = memStb & memRsp.ack;
  assign lineDone = memAck & lastWord;

  always_comb begin
    memReq.cyc = memStb;
    memReq.stb = memStb;
    memReq.we = memStb & (state != cacheTypesPkg::refill);
    memReq.sel = 4'hf;
    memReq.dat = readWord;
    if (state == cacheTypesPkg::refill) begin
      memReq.adr = {cpuTag, cpuSet, wordIdx, 2'b00};
    end else begin
      // Victim line, either on a miss or during the flush walk
      memReq.adr = {victimTag, setIdx, wordIdx, 2'b00};
    end
  end

  assign cpuRsp.ack = (state == cacheTypesPkg::complete);
  assign cpuRsp.dat = readWord;

  // Array addressing
  assign flushBusy = state inside {cacheTypesPkg::flushScan, cacheTypesPkg::flushWrite};
  assign setIdx = flushBusy ? flushSet : cpuSet;
  assign dataWordIdx = memXfer ? wordIdx : cpuWord;

  always_comb begin
    if (flushBusy) begin
      wayIdx = flushWay;
    end else if (state == cacheTypesPkg::lookup) begin
      wayIdx = hit ? hitWay : victimWay;
    end else begin
      wayIdx = accWay;
    end
  end

  // Refill word that the processor is writing
  assign mergeWord = cpuReq.we & (wordIdx == cpuWord);

  always_comb begin
    dataWe = 1'b0;
    dataSel = cpuReq.sel;
    dataIn = cpuReq.dat;
    if (state == cacheTypesPkg::lookup) begin
      dataWe = hit & cpuReq.we;
    end else if (state == cacheTypesPkg::refill) begin
      dataWe = memAck;
      dataSel = 4'hf;
      for (int lane = 0; lane < 4; lane++) begin
        dataIn[8*lane +: 8] = (mergeWord && cpuReq.sel[lane]) ? cpuReq.dat[8*lane +: 8]
                                                              : memRsp.dat[8*lane +: 8];
      end
    end
  end

  always_comb begin
    tagWrite = 1'b0;
    metaWrite = 1'b0;
    lruUpdate = 1'b0;
    newMeta.valid = 1'b1;
    newMeta.dirty = cpuReq.we;
    case (state)
      cacheTypesPkg::lookup: begin
        metaWrite = hit & cpuReq.we;
        lruUpdate = hit;
      end
      cacheTypesPkg::refill: begin
        tagWrite = lineDone;
        metaWrite = lineDone;
        lruUpdate = lineDone;
      end
      cacheTypesPkg::flushWrite: begin
        // Line stays valid but is now clean
        metaWrite = lineDone;
        newMeta.dirty = 1'b0;
      end
      default: ;
    endcase
  end

  // Counter strobes
  assign wordInc = memAck;
  assign clear = (state == cacheTypesPkg::idle);
  assign flushInc = (state == cacheTypesPkg::flushScan) & ~flushDone & ~victimDirty
                  | (state == cacheTypesPkg::flushWrite) & lineDone;

endmodule

`default_nettype wire

//--- src/dataCache.sv
`timescale 1ns/10ps
`default_nettype none

module dataCache #(
  parameter int numSets = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  busTypesPkg::wbReq cpuReq,
  output busTypesPkg::wbRsp cpuRsp,
  output busTypesPkg::wbReq memReq,
  input  busTypesPkg::wbRsp memRsp,
  input  logic              flushReq,
  output logic              flushBusy
);

  localparam int indexWidth = $clog2(numSets);
  localparam int tagWidth = cacheTypesPkg::addrWidth - indexWidth
                            - cacheTypesPkg::lineOffsetWidth;

  // Lookup results
  logic                   hit;
  logic                   hitWay;
  logic                   victimWay;
  cacheTypesPkg::lineMeta victimMeta;
  logic [tagWidth-1:0]    victimTag;
  logic [31:0]            readWord;

  // Counters
  logic [1:0]             wordIdx;
  logic                   lastWord;
  logic [indexWidth-1:0]  flushSet;
  logic                   flushWay;
  logic                   flushDone;
  logic                   wordInc;
  logic                   flushInc;
  logic                   clear;

  // Array control
  logic                   tagWrite;
  logic                   metaWrite;
  logic                   lruUpdate;
  logic [indexWidth-1:0]  setIdx;
  logic                   wayIdx;
  logic                   dataWe;
  logic [3:0]             dataSel;
  logic [1:0]             dataWordIdx;
  logic [31:0]            dataIn;
  cacheTypesPkg::lineMeta newMeta;

  cacheController #(.numSets(numSets)) controller0 (.*);

  burstCounter #(.numSets(numSets)) counter0 (.*);

  tagStore #(.numSets(numSets)) tags0 (
    .clk(clk),
    .reset(reset),
    .setIdx(setIdx),
    .wayIdx(wayIdx),
    .lookupTag(cpuReq.adr[cacheTypesPkg::addrWidth-1 -: tagWidth]),
    .tagWrite(tagWrite),
    .metaWrite(metaWrite),
    .lruUpdate(lruUpdate),
    .newMeta(newMeta),
    .hit(hit),
    .hitWay(hitWay),
    .victimWay(victimWay),
    .victimMeta(victimMeta),
    .victimTag(victimTag)
  );

  dataStore #(.numSets(numSets)) data0 (
    .clk(clk),
    .setIdx(setIdx),
    .wayIdx(wayIdx),
    .wordIdx(dataWordIdx),
    .dataWe(dataWe),
    .dataSel(dataSel),
    .dataIn(dataIn),
    .readWord(readWord)
  );

endmodule

`default_nettype wire

//--- testbench/controller_properties.sv
`timescale 1ns/10ps
`default_nettype none

module controllerProperties (
  input logic                    clk,
  input logic                    reset,
  input cacheTypesPkg::ctrlState state,
  input busTypesPkg::wbReq       cpuReq,
  input busTypesPkg::wbRsp       cpuRsp,
  input busTypesPkg::wbReq       memReq,
  input busTypesPkg::wbRsp       memRsp,
  input logic                    flushBusy
);

  // Number of failed assertions
  int failCount = 0;

  // Single cycle acknowledge toward the processor
  ackOneCycle: assert property (@(posedge clk) disable iff (reset)
    cpuRsp.ack |=> !cpuRsp.ack)
    else begin
      failCount++;
      $error("cpuRsp.ack held for more than one cycle");
    end

  // Memory request waits unchanged for its ack
  memHeld: assert property (@(posedge clk) disable iff (reset)
    (memReq.stb && !memRsp.ack) |=> (memReq.stb && $stable(memReq.adr)))
    else begin
      failCount++;
      $error("memReq changed before ack");
    end

  // Memory bus stays quiet without a processor request or a flush
  noIdleTransfer: assert property (@(posedge clk) disable iff (reset)
    (!flushBusy && !(cpuReq.cyc && cpuReq.stb)) |-> !memReq.cyc)
    else begin
      failCount++;
      $error("memory transfer started without a request");
    end

  legalState: assert property (@(posedge clk) disable iff (reset)
    state inside {cacheTypesPkg::idle, cacheTypesPkg::lookup, cacheTypesPkg::writeBack,
                  cacheTypesPkg::refill, cacheTypesPkg::complete,
                  cacheTypesPkg::flushScan, cacheTypesPkg::flushWrite})
    else begin
      failCount++;
      $error("controller state outside the enum");
    end

endmodule

`default_nettype wire

//--- testbench/cacheChecker.sv
`timescale 1ns/10ps
`default_nettype none

module cacheChecker #(
  parameter int numSets = 4
) (
  input logic              clk,
  input logic              reset,
  input busTypesPkg::wbReq cpuReq,
  input busTypesPkg::wbRsp cpuRsp,
  input busTypesPkg::wbReq memReq,
  input busTypesPkg::wbRsp memRsp,
  input logic              flushBusy
);

  localparam int indexWidth = $clog2(numSets);

  // Latest value of every memory word as the processor sees it
  logic [31:0] shadow [1024];
  logic        refValid [numSets][2];
  logic        refDirty [numSets][2];
  logic [31:0] refTag [numSets][2];
  logic        refLru [numSets];
  int          memReads = 0;
  int          memWrites = 0;
  int          expReads;
  int          expWrites;
  int          errorCount = 0;
  int          testErrors = 0;
  int          testCount = 0;
  int          failedTests = 0;
  logic        wasBusy = 1'b0;

  task automatic reportValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    errorCount++;
    testErrors++;
    $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
  endtask

  task automatic reportProblem(input string text);
    errorCount++;
    testErrors++;
    $display("Error at %0t: %s", $time, text);
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (testErrors == 0) begin
      $display("test %s: ok", name);
    end else begin
      failedTests++;
      $display("test %s: failed with %0d errors", name, testErrors);
    end
    testErrors = 0;
  endtask

  // Expected traffic of one access and the tag model after it
  function automatic void refAccess(input logic [31:0] adr, input logic we,
                                    output int reads, output int writes);
    int          setNum;
    int          way;
    logic [31:0] tag;
    setNum = int'((adr >> 4) % numSets);
    tag = adr >> (4 + indexWidth);
    reads = 0;
    writes = 0;
    if (refValid[setNum][0] && refTag[setNum][0] == tag) begin
      way = 0;
    end else if (refValid[setNum][1] && refTag[setNum][1] == tag) begin
      way = 1;
    end else begin
      if (!refValid[setNum][0]) begin
        way = 0;
      end else if (!refValid[setNum][1]) begin
        way = 1;
      end else begin
        way = int'(refLru[setNum]);
      end
      if (refValid[setNum][way] && refDirty[setNum][way]) begin
        writes = 4;
      end
      reads = 4;
      refValid[setNum][way] = 1'b1;
      refTag[setNum][way] = tag;
      refDirty[setNum][way] = 1'b0;
    end
    if (we) begin
      refDirty[setNum][way] = 1'b1;
    end
    refLru[setNum] = (way == 0);
  endfunction

  // Expected write count of a flush that leaves every line clean
  function automatic int refFlush();
    int lines;
    lines = 0;
    for (int s = 0; s < numSets; s++) begin
      for (int w = 0; w < 2; w++) begin
        if (refValid[s][w] && refDirty[s][w]) begin
          lines++;
        end
        refDirty[s][w] = 1'b0;
      end
    end
    return lines * 4;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 1024; i++) begin
        shadow[i] = cacheTb.memory[i];
      end
      for (int s = 0; s < numSets; s++) begin
        refLru[s] = 1'b0;
        for (int w = 0; w < 2; w++) begin
          refValid[s][w] = 1'b0;
          refDirty[s][w] = 1'b0;
          refTag[s][w] = '0;
        end
      end
      memReads = 0;
      memWrites = 0;
      wasBusy = 1'b0;
    end else begin
      if (memReq.stb && memRsp.ack) begin
        if (!memReq.cyc) begin
          reportProblem("memReq.stb raised without memReq.cyc");
        end
        // Word-wide memory bus
        if (memReq.sel !== 4'hf) begin
          reportValue("memReq.sel", 32'hf, 32'(memReq.sel));
        end
        if (memReq.we) begin
          // Write-back must come before the refill
          if (memReads > 0) begin
            reportProblem("memory write seen after the refill started");
          end
          if (memReq.dat !== shadow[memReq.adr[11:2]]) begin
            reportValue("memReq.dat", shadow[memReq.adr[11:2]], memReq.dat);
          end
          memWrites++;
        end else begin
          if (memReq.adr[31:4] != cpuReq.adr[31:4]) begin
            reportValue("memReq.adr", {cpuReq.adr[31:4], memReq.adr[3:0]}, memReq.adr);
          end
          memReads++;
        end
      end
      if (cpuRsp.ack) begin
        refAccess(cpuReq.adr, cpuReq.we, expReads, expWrites);
        if (!cpuReq.we && cpuRsp.dat !== shadow[cpuReq.adr[11:2]]) begin
          reportValue("cpuRsp.dat", shadow[cpuReq.adr[11:2]], cpuRsp.dat);
        end
        if (memReads != expReads) begin
          reportValue("memory reads", 32'(expReads), 32'(memReads));
        end
        if (memWrites != expWrites) begin
          reportValue("memory writes", 32'(expWrites), 32'(memWrites));
        end
        if (cpuReq.we) begin
          for (int lane = 0; lane < 4; lane++) begin
            if (cpuReq.sel[lane]) begin
              shadow[cpuReq.adr[11:2]][8*lane +: 8] = cpuReq.dat[8*lane +: 8];
            end
          end
        end
        memReads = 0;
        memWrites = 0;
      end
      if (wasBusy && !flushBusy) begin
        expWrites = refFlush();
        if (memWrites != expWrites) begin
          reportValue("flush writes", 32'(expWrites), 32'(memWrites));
        end
        if (memReads != 0) begin
          reportProblem("memory read during a flush");
        end
        for (int i = 0; i < 1024; i++) begin
          if (cacheTb.memory[i] !== shadow[i]) begin
            reportValue($sformatf("memory[%0d]", i), shadow[i], cacheTb.memory[i]);
          end
        end
        memReads = 0;
        memWrites = 0;
      end
      wasBusy = flushBusy;
    end
  end

endmodule

`default_nettype wire

//--- testbench/cacheTb.sv
`timescale 1ns/10ps
`default_nettype none

module cacheTb;

  localparam int numSets = 4;
  localparam int numAccesses = 317;
  localparam int numFlushes = 3;
  // Worst case miss is 8 transfers of 5 cycles plus the lookup
  localparam int cycleLimit = numAccesses * (8 * 5 + 4) + numFlushes * 2 * numSets * 40 + 20;

  logic              clk = 1'b0;
  logic              reset = 1'b1;
  logic              flushReq = 1'b0;
  logic              flushBusy;
  busTypesPkg::wbReq cpuReq = '0;
  busTypesPkg::wbRsp cpuRsp;
  busTypesPkg::wbReq memReq;
  busTypesPkg::wbRsp memRsp = '0;
  integer            seed = 32'h174e_47d9;
  int                cycleCount = 0;
  logic [31:0]       memory [1024];
  logic              memBusy = 1'b0;
  logic [1:0]        memWait = '0;
  logic [31:0]       mixAddr [8];

  always #2 clk = ~clk;

  dataCache #(.numSets(numSets)) dut0 (
    .clk(clk),
    .reset(reset),
    .cpuReq(cpuReq),
    .cpuRsp(cpuRsp),
    .memReq(memReq),
    .memRsp(memRsp),
    .flushReq(flushReq),
    .flushBusy(flushBusy)
  );

  cacheChecker #(.numSets(numSets)) checker0 (
    .clk(clk),
    .reset(reset),
    .cpuReq(cpuReq),
    .cpuRsp(cpuRsp),
    .memReq(memReq),
    .memRsp(memRsp),
    .flushBusy(flushBusy)
  );

  bind cacheController controllerProperties props0 (
    .clk(clk),
    .reset(reset),
    .state(state),
    .cpuReq(cpuReq),
    .cpuRsp(cpuRsp),
    .memReq(memReq),
    .memRsp(memRsp),
    .flushBusy(flushBusy)
  );

  // Word memory filled from the full word index
  initial begin
    for (int i = 0; i < 1024; i++) begin
      memory[i] = (i * 32'h0001_0003) ^ (i << 20) ^ 32'h5a5a_0000;
    end
  end

  // One cycle ack after 1 to 3 cycles
  always @(posedge clk) begin
    if (memRsp.ack) begin
      memRsp.ack <= 1'b0;
      memBusy <= 1'b0;
    end else if (memReq.stb && !memBusy) begin
      memBusy <= 1'b1;
      memWait <= 2'($unsigned($random(seed)) % 32'd3);
    end else if (memBusy) begin
      if (memWait == 2'd0) begin
        memRsp.ack <= 1'b1;
        memRsp.dat <= memory[memReq.adr[11:2]];
        if (memReq.we) begin
          memory[memReq.adr[11:2]] <= memReq.dat;
        end
      end else begin
        memWait <= memWait - 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycleCount);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic cpuAccess(input logic [31:0] adr, input logic we,
                           input logic [31:0] dat, input logic [3:0] sel);
    @(posedge clk);
    cpuReq.cyc <= 1'b1;
    cpuReq.stb <= 1'b1;
    cpuReq.we <= we;
    cpuReq.sel <= sel;
    cpuReq.adr <= adr;
    cpuReq.dat <= dat;
    do begin
      @(posedge clk);
    end while (!cpuRsp.ack);
    cpuReq.cyc <= 1'b0;
    cpuReq.stb <= 1'b0;
    cpuReq.we <= 1'b0;
  endtask

  task automatic cpuRead(input logic [31:0] adr);
    cpuAccess(adr, 1'b0, 32'h0, 4'hf);
  endtask

  task automatic cpuWrite(input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel);
    cpuAccess(adr, 1'b1, dat, sel);
  endtask

  task automatic flushCache();
    @(posedge clk);
    flushReq <= 1'b1;
    do begin
      @(posedge clk);
    end while (!flushBusy);
    flushReq <= 1'b0;
    do begin
      @(posedge clk);
    end while (flushBusy);
  endtask

  // Lets the checker finish the last access first
  task automatic endTest(input string name);
    @(posedge clk);
    checker0.finishTest(name);
  endtask

  initial begin
    int          pick;
    logic [3:0]  sel;
    int          errors;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    cpuRead(32'h100);
    cpuRead(32'h104);
    endTest("read miss then hit");

    cpuWrite(32'h104, 32'hdead_beef, 4'b0101);
    cpuRead(32'h104);
    endTest("partial write hit");

    // Three tags in set 0
    cpuRead(32'h200);
    cpuRead(32'h600);
    cpuRead(32'h200);
    cpuRead(32'ha00);
    cpuRead(32'h200);
    cpuRead(32'h600);
    endTest("LRU replacement");

    cpuWrite(32'h810, 32'h1234_5678, 4'b1100);
    cpuRead(32'hc10);
    cpuRead(32'h1010);
    cpuRead(32'h1410);
    endTest("dirty eviction");

    cpuWrite(32'h020, 32'h0bad_f00d, 4'hf);
    cpuWrite(32'h030, 32'hcafe_0001, 4'b0011);
    cpuWrite(32'h0a0, 32'h7777_8888, 4'b1000);
    flushCache();
    flushCache();
    endTest("flush");

    mixAddr[0] = 32'h000;
    mixAddr[1] = 32'h040;
    mixAddr[2] = 32'h080;
    mixAddr[3] = 32'h0c0;
    mixAddr[4] = 32'h004;
    mixAddr[5] = 32'h014;
    mixAddr[6] = 32'h054;
    mixAddr[7] = 32'h118;
    for (int n = 0; n < 300; n++) begin
      pick = int'($unsigned($random(seed)) % 32'd8);
      if ($random(seed) & 1) begin
        sel = 4'($random(seed));
        if (sel == 4'h0) begin
          sel = 4'hf;
        end
        cpuWrite(mixAddr[pick], $random(seed), sel);
      end else begin
        cpuRead(mixAddr[pick]);
      end
    end
    flushCache();
    endTest("random mix");

    errors = checker0.errorCount + dut0.controller0.props0.failCount;
    $display("tests %0d, failed %0d, errors %0d",
             checker0.testCount, checker0.failedTests, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/cacheTypesPkg.sv
src/busTypesPkg.sv
src/burstCounter.sv
src/tagStore.sv
src/dataStore.sv
src/cacheController.sv
src/dataCache.sv
testbench/controller_properties.sv
testbench/cacheChecker.sv
testbench/cacheTb.sv

//--- Makefile
# Verilator flow for the data cache testbench
VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
